// File: rdp_width_pkg.sv
`default_nettype none

// Data widths of the read data mapping
// Capture data arrives group-major, and the AFI expects it timeslot-major
package rdp_width_pkg;

	// ********************
	// Memory side
	// ********************

	// Read DQS groups on the memory interface
	localparam int NUM_DQS_GROUPS = 2;

	// DQ bits captured by one DQS group
	localparam int DQ_GROUP_WIDTH = 8;

	// Full DQ width seen at the pads
	localparam int MEM_DQ_WIDTH = NUM_DQS_GROUPS * DQ_GROUP_WIDTH;

	// ********************
	// AFI side
	// ********************

	// Quarter rate with DDR gives four full-rate beats per AFI cycle
	localparam int NUM_TIMESLOTS = 4;

	// One AFI word carries every beat of every group
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// Slice of the AFI word owned by one group, all timeslots together
	localparam int GROUP_DATA_WIDTH = AFI_DATA_WIDTH / NUM_DQS_GROUPS;

endpackage

`default_nettype wire

// File: rdp_timing_pkg.sv
`default_nettype none

// Timing constants of the read enable, read valid and termination paths
package rdp_timing_pkg;

	// ********************
	// Rate and latency
	// ********************

	// AFI phases per pll_afi_clk cycle
	localparam int AFI_RATE_RATIO = 4;

	// Phases 0 and 2 stand in for the pairs {0,1} and {2,3}
	localparam int LFIFO_PAIRS = 2;

	// Depth of each latency shift register, in AFI cycles
	localparam int MAX_READ_LATENCY = 32;

	// Width of the latency value programmed by the sequencer
	localparam int LATENCY_COUNT_WIDTH = $clog2(MAX_READ_LATENCY);

	// ********************
	// Termination window
	// ********************

	// Memory read latency in full-rate clocks
	localparam int MEM_T_RL = 11;

	// Start and end of the OCT-off window, converted to AFI cycles
	localparam int OCT_ON_DELAY = (MEM_T_RL + 2) / 4;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 14) / 4;

endpackage

`default_nettype wire

// File: rdp_enable_align.sv
`default_nettype none

// Front end of the read control path
// The read enables get one extra register stage, which matches the delay
// the I/O pads add on the data side. Only the first phase of each phase
// pair is tracked further down, so the four phases collapse to two
module rdp_enable_align
	import rdp_timing_pkg::*;
(
	input  wire                      pll_afi_clk,
	input  wire                      reset_n_afi_clk,
	input  wire [AFI_RATE_RATIO-1:0] afi_rdata_en_i,
	input  wire [AFI_RATE_RATIO-1:0] afi_rdata_en_full_i,
	output logic [LFIFO_PAIRS-1:0]   en_pair_o,
	output logic                     full_any_o
);

	// ********************
	// Enable alignment
	// ********************

	// Pair p is represented by phase p times the pair stride, so phases 0 and 2
	// Phases 1 and 3 carry the same request and are dropped here
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_pair_o <= '0;
		end
		else
		begin
			for (int p = 0; p < LFIFO_PAIRS; p++)
				en_pair_o[p] <= afi_rdata_en_i[p * (AFI_RATE_RATIO / LFIFO_PAIRS)];
		end
	end

	// Any full-rate enable on a tracked phase opens the termination window
	// This stays combinational, the OCT history register adds the stage
	always_comb
	begin
		full_any_o = 1'b0;
		for (int p = 0; p < LFIFO_PAIRS; p++)
			full_any_o = full_any_o | afi_rdata_en_full_i[p * (AFI_RATE_RATIO / LFIFO_PAIRS)];
	end

endmodule

`default_nettype wire

// File: rdp_latency_shifter.sv
`default_nettype none

// Read valid generation
// Each tracked phase pair owns a shift register that records the read
// enables of the last MAX_READ_LATENCY cycles. The sequencer programs the
// tap that lines up with returning read data, which becomes afi_rdata_valid
module rdp_latency_shifter
	import rdp_timing_pkg::*;
(
	input  wire                           pll_afi_clk,
	input  wire                           reset_n_afi_clk,
	input  wire [LFIFO_PAIRS-1:0]         en_pair_i,
	input  wire [LATENCY_COUNT_WIDTH-1:0] latency_i,
	output logic [AFI_RATE_RATIO-1:0]     rdata_valid_o
);

	// Bit k of a shifter holds the enable seen k+1 cycles before
	logic [MAX_READ_LATENCY-1:0] shift_q [LFIFO_PAIRS];

	// Selected tap per pair, one register stage ahead of the output
	logic [LFIFO_PAIRS-1:0] tap_q;

	// ********************
	// Latency shift registers
	// ********************

	// The shifters run every cycle, a zero is a cycle with no read
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			for (int p = 0; p < LFIFO_PAIRS; p++)
				shift_q[p] <= '0;
		end
		else
		begin
			for (int p = 0; p < LFIFO_PAIRS; p++)
				shift_q[p] <= {shift_q[p][MAX_READ_LATENCY-2:0], en_pair_i[p]};
		end
	end

	// ********************
	// Tap selection
	// ********************

	// latency_i is held static while reads are in flight, so the mux
	// select never moves under a token
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			tap_q <= '0;
		end
		else
		begin
			for (int p = 0; p < LFIFO_PAIRS; p++)
				tap_q[p] <= shift_q[p][latency_i];
		end
	end

	// Every group shares one latency counter, so one tap per pair serves
	// all groups and no AND across groups is needed
	// Each pair is copied onto both of its phases
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_valid_o <= '0;
		end
		else
		begin
			for (int ph = 0; ph < AFI_RATE_RATIO; ph++)
				rdata_valid_o[ph] <= tap_q[ph / (AFI_RATE_RATIO / LFIFO_PAIRS)];
		end
	end

endmodule

`default_nettype wire

// File: rdp_oct_window.sv
`default_nettype none

// Termination control for the read path
// On-die termination must be on while read data returns from the memory.
// A short history of full-rate read enables tells when that is, and
// force_oct_off stays low for the whole window
module rdp_oct_window
	import rdp_timing_pkg::*;
#(
	parameter int NUM_GROUPS = 2
)
(
	input  wire                   pll_afi_clk,
	input  wire                   reset_n_afi_clk,
	input  wire                   full_any_i,
	output logic [NUM_GROUPS-1:0] force_oct_off_o
);

	// Bit k holds full_any from k cycles before the most recent edge
	logic [OCT_OFF_DELAY:0] hist_q;

	// High while a past read falls into the data return window
	logic window_hit;

	// ********************
	// Enable history
	// ********************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			hist_q <= '0;
		end
		else
		begin
			hist_q <= {hist_q[OCT_OFF_DELAY-1:0], full_any_i};
		end
	end

	assign window_hit = |hist_q[OCT_OFF_DELAY:OCT_ON_DELAY];

	// Overlapping reads simply merge into one longer window
	// Out of reset termination is not forced off until the history is known
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			force_oct_off_o <= '0;
		end
		else
		begin
			force_oct_off_o <= {NUM_GROUPS{~window_hit}};
		end
	end

endmodule

`default_nettype wire

// File: rdp_data_remap.sv
`default_nettype none

// Read data mapping
// Capture data arrives ordered by DQS group with the timeslot inside:
//   G1_T3 G1_T2 G1_T1 G1_T0 G0_T3 G0_T2 G0_T1 G0_T0
// The AFI wants it ordered by timeslot with the group inside:
//   G1_T3 G0_T3 G1_T2 G0_T2 G1_T1 G0_T1 G1_T0 G0_T0
// The sequencer copy goes back to group order for per-group calibration
module rdp_data_remap
	import rdp_width_pkg::*;
(
	input  wire                      pll_afi_clk,
	input  wire [AFI_DATA_WIDTH-1:0] phy_dq_i,
	output wire [AFI_DATA_WIDTH-1:0] afi_rdata_o,
	output wire [AFI_DATA_WIDTH-1:0] seq_rdata_o
);

	// Captured word, still in group-major order
	logic [AFI_DATA_WIDTH-1:0] dq_q;

	// ********************
	// Capture register
	// ********************

	// Validity travels on afi_rdata_valid, so the data flops only follow
	always_ff @(posedge pll_afi_clk)
	begin
		dq_q <= phy_dq_i;
	end

	// ********************
	// Reordering
	// ********************

	// Group g, timeslot t sits at g*GROUP_DATA_WIDTH + t*DQ_GROUP_WIDTH in
	// the capture word and at t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH on the AFI
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : g_group
		for (genvar t = 0; t < NUM_TIMESLOTS; t++)
		begin : g_slot
			// Group-major to timeslot-major for the controller
			assign afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				dq_q[g*GROUP_DATA_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];

			// And back again, taken from the AFI word so both buses always agree
			assign seq_rdata_o[g*GROUP_DATA_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: rdp_read_datapath.sv
`default_nettype none

// Read datapath of the quarter-rate PHY, all on pll_afi_clk
// Read enables from the controller are turned into afi_rdata_valid after
// the programmed read latency, termination is forced off outside the read
// data window, and captured data is reordered for the AFI and the sequencer
module rdp_read_datapath
	import rdp_width_pkg::*, rdp_timing_pkg::*;
(
	input  wire                           pll_afi_clk,
	input  wire                           reset_n_afi_clk,

	// Read requests from the controller, one bit per AFI phase
	input  wire [AFI_RATE_RATIO-1:0]      afi_rdata_en_i,
	input  wire [AFI_RATE_RATIO-1:0]      afi_rdata_en_full_i,

	// Read latency found by calibration
	input  wire [LATENCY_COUNT_WIDTH-1:0] seq_read_latency_counter_i,

	// Captured read data, group-major
	input  wire [AFI_DATA_WIDTH-1:0]      phy_dq_i,

	output wire [AFI_DATA_WIDTH-1:0]      afi_rdata_o,
	output wire [AFI_RATE_RATIO-1:0]      afi_rdata_valid_o,
	output wire [AFI_DATA_WIDTH-1:0]      phy_mux_read_fifo_q_o,
	output wire [NUM_DQS_GROUPS-1:0]      force_oct_off_o
);

	// Aligned enables for phases 0 and 2
	wire [LFIFO_PAIRS-1:0] en_pair;

	// Full-rate enable seen on any tracked phase
	wire full_any;

	// ********************
	// Read control
	// ********************

	rdp_enable_align i_enable_align (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_i      (afi_rdata_en_i),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.en_pair_o           (en_pair),
		.full_any_o          (full_any)
	);

	rdp_latency_shifter i_latency_shifter (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.en_pair_i       (en_pair),
		.latency_i       (seq_read_latency_counter_i),
		.rdata_valid_o   (afi_rdata_valid_o)
	);

	// One termination control bit per read DQS group
	rdp_oct_window #(
		.NUM_GROUPS (NUM_DQS_GROUPS)
	) i_oct_window (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.full_any_i      (full_any),
		.force_oct_off_o (force_oct_off_o)
	);

	// ********************
	// Read data
	// ********************

	rdp_data_remap i_data_remap (
		.pll_afi_clk (pll_afi_clk),
		.phy_dq_i    (phy_dq_i),
		.afi_rdata_o (afi_rdata_o),
		.seq_rdata_o (phy_mux_read_fifo_q_o)
	);

endmodule

`default_nettype wire

// File: rdp_read_datapath_asserts.sv
`default_nettype none

// Output checks on the read datapath, bound into every instance of the top level
module rdp_read_datapath_asserts
	import rdp_width_pkg::*, rdp_timing_pkg::*;
(
	input wire                      pll_afi_clk,
	input wire                      reset_n_afi_clk,
	input wire [AFI_RATE_RATIO-1:0] valid_i,
	input wire [NUM_DQS_GROUPS-1:0] force_oct_off_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// Both phases of a pair come from one tap, so they always agree
	pair_equal_a: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(valid_i[0] == valid_i[1]) && (valid_i[2] == valid_i[3])
	)
	else
		$error("Valid bits of a phase pair differ");

	// No read data is announced while the path is held in reset
	valid_reset_a: assert property (
		@(posedge pll_afi_clk) !reset_n_afi_clk |-> (valid_i == '0)
	)
	else
		$error("afi_rdata_valid is set while in reset");

	// Termination is left alone until the enable history is known
	oct_reset_a: assert property (
		@(posedge pll_afi_clk) !reset_n_afi_clk |-> (force_oct_off_i == '0)
	)
	else
		$error("force_oct_off is set while in reset");

endmodule

bind rdp_read_datapath rdp_read_datapath_asserts i_asserts (
	.pll_afi_clk     (pll_afi_clk),
	.reset_n_afi_clk (reset_n_afi_clk),
	.valid_i         (afi_rdata_valid_o),
	.force_oct_off_i (force_oct_off_o)
);

`default_nettype wire

// File: tb_rdp_read_datapath.sv
`default_nettype none

// Directed testbench for the read datapath
// Each slot starts a short delay after a rising edge. Inputs driven in a slot
// are sampled on the next edge, and the outputs seen in a slot show the state
// after the edge that opened it
module tb_rdp_read_datapath
	import rdp_width_pkg::*, rdp_timing_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	// Long enough to empty the latency shifters and the OCT history
	localparam int FLUSH_CYCLES = MAX_READ_LATENCY + 4;
	localparam int SEQ_MAX = 32;
	localparam int DATA_WORDS = 24;
	// Upper bound on the length of all tests with at most twenty sequence runs
	localparam int TEST_CYCLES = RESET_CYCLES + 2
		+ 20 * (FLUSH_CYCLES + SEQ_MAX + MAX_READ_LATENCY + 10) + DATA_WORDS + 2;
	localparam int MARGIN_CYCLES = 200;

	logic                           pll_afi_clk;
	logic                           reset_n_afi_clk;
	logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_i;
	logic [AFI_RATE_RATIO-1:0]      afi_rdata_en_full_i;
	logic [LATENCY_COUNT_WIDTH-1:0] seq_read_latency_counter_i;
	logic [AFI_DATA_WIDTH-1:0]      phy_dq_i;
	wire  [AFI_DATA_WIDTH-1:0]      afi_rdata_o;
	wire  [AFI_RATE_RATIO-1:0]      afi_rdata_valid_o;
	wire  [AFI_DATA_WIDTH-1:0]      phy_mux_read_fifo_q_o;
	wire  [NUM_DQS_GROUPS-1:0]      force_oct_off_o;

	int error_count;
	int check_count;
	integer seed;

	// Stimulus for one run, one entry per slot
	logic [AFI_RATE_RATIO-1:0] en_seq [SEQ_MAX];
	logic [AFI_RATE_RATIO-1:0] full_seq [SEQ_MAX];
	int seq_len;

	rdp_read_datapath i_dut (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.phy_dq_i                   (phy_dq_i),
		.afi_rdata_o                (afi_rdata_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	always
	begin
		#(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
	end

	// ********************
	// Helpers
	// ********************

	task automatic check_value(input logic [AFI_DATA_WIDTH-1:0] actual,
		input logic [AFI_DATA_WIDTH-1:0] expected, input string what);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	// Move to the drive point of the next slot
	task automatic advance_cycle();
		@(posedge pll_afi_clk);
		#DRIVE_DELAY;
	endtask

	task automatic clear_seqs();
		for (int i = 0; i < SEQ_MAX; i++)
		begin
			en_seq[i] = '0;
			full_seq[i] = '0;
		end
	endtask

	task automatic flush_pipeline(input int cycles);
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
		repeat (cycles) advance_cycle();
	endtask

	// Group g, timeslot t goes to timeslot t, group g of the AFI word
	// The word is built from the top timeslot down with the groups inside
	function automatic logic [AFI_DATA_WIDTH-1:0] to_timeslot_major(
		input logic [AFI_DATA_WIDTH-1:0] word);
		logic [AFI_DATA_WIDTH-1:0] result;
		logic [AFI_DATA_WIDTH-1:0] slice;
		result = '0;
		for (int t = NUM_TIMESLOTS - 1; t >= 0; t--)
		begin
			for (int g = NUM_DQS_GROUPS - 1; g >= 0; g--)
			begin
				slice = (word >> (g * GROUP_DATA_WIDTH + t * DQ_GROUP_WIDTH))
					& {DQ_GROUP_WIDTH{1'b1}};
				result = (result << DQ_GROUP_WIDTH) | slice;
			end
		end
		return result;
	endfunction

	// Plays en_seq and full_seq from slot 0 and checks valid and OCT per slot
	// Valid follows the enable driven L+4 slots before with the pair bits duplicated
	// force_oct_off goes low while a tracked full enable lies 5 to 8 slots back
	task automatic run_sequence(input int lat, input string name);
		int j;
		logic [AFI_RATE_RATIO-1:0] exp_valid;
		logic [NUM_DQS_GROUPS-1:0] exp_oct;
		flush_pipeline(FLUSH_CYCLES);
		seq_read_latency_counter_i = lat[LATENCY_COUNT_WIDTH-1:0];
		for (int i = 0; i < seq_len + lat + 10; i++)
		begin
			afi_rdata_en_i = (i < seq_len) ? en_seq[i] : '0;
			afi_rdata_en_full_i = (i < seq_len) ? full_seq[i] : '0;
			exp_valid = '0;
			j = i - lat - 4;
			if (j >= 0 && j < seq_len)
				exp_valid = {{2{en_seq[j][2]}}, {2{en_seq[j][0]}}};
			exp_oct = '1;
			for (int k = i - 8; k <= i - 5; k++)
			begin
				if (k >= 0 && k < seq_len && (full_seq[k][0] || full_seq[k][2]))
					exp_oct = '0;
			end
			check_value(afi_rdata_valid_o, exp_valid,
				$sformatf("%s valid, L=%0d, slot %0d", name, lat, i));
			check_value(force_oct_off_o, exp_oct,
				$sformatf("%s force_oct_off, slot %0d", name, i));
			advance_cycle();
		end
	endtask

	// Single-cycle reads on each phase pair and then on the untracked phases only
	task automatic single_pulse_reads(input int lat);
		clear_seqs();
		seq_len = 1;
		en_seq[0] = 4'b0001;
		run_sequence(lat, "phase 0 pulse");
		en_seq[0] = 4'b0100;
		run_sequence(lat, "phase 2 pulse");
		en_seq[0] = 4'b1010;
		run_sequence(lat, "phase 1 and 3 pulse");
	endtask

	// ********************
	// Tests
	// ********************

	task automatic verify_reset_state();
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			advance_cycle();
			check_value(afi_rdata_valid_o, '0, "valid during reset");
			check_value(force_oct_off_o, '0, "force_oct_off during reset");
		end
		reset_n_afi_clk = 1'b1;
		advance_cycle();
		check_value(afi_rdata_valid_o, '0, "valid after reset");
		check_value(force_oct_off_o, {NUM_DQS_GROUPS{1'b1}}, "force_oct_off after reset");
	endtask

	task automatic sweep_valid_latency();
		single_pulse_reads(0);
		single_pulse_reads(5);
		single_pulse_reads(11);
		single_pulse_reads(31);
	endtask

	task automatic burst_reads();
		integer r;
		// A five-cycle read on phase 0
		clear_seqs();
		seq_len = 5;
		for (int i = 0; i < 5; i++)
			en_seq[i] = 4'b0001;
		run_sequence(7, "long burst");
		// Back-to-back reads of mixed length, several in flight at once
		clear_seqs();
		seq_len = 12;
		en_seq[0] = 4'b0101;
		en_seq[1] = 4'b0101;
		en_seq[2] = 4'b0101;
		en_seq[4] = 4'b0100;
		en_seq[5] = 4'b0100;
		en_seq[6] = 4'b0001;
		en_seq[7] = 4'b0101;
		en_seq[8] = 4'b0101;
		en_seq[9] = 4'b0101;
		en_seq[11] = 4'b0001;
		run_sequence(7, "back-to-back");
		run_sequence(2, "back-to-back short latency");
		// Random enables on all four phases
		clear_seqs();
		seq_len = 16;
		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			en_seq[i] = r[AFI_RATE_RATIO-1:0];
		end
		run_sequence(20, "random reads");
	endtask

	task automatic oct_window_reads();
		clear_seqs();
		seq_len = 1;
		full_seq[0] = 4'b0001;
		run_sequence(0, "isolated OCT pulse");
		// Three close reads give one merged window
		clear_seqs();
		seq_len = 4;
		full_seq[0] = 4'b0100;
		full_seq[2] = 4'b0001;
		full_seq[3] = 4'b0101;
		run_sequence(0, "overlapping OCT pulses");
		// Separate windows with an ignored pulse on phases 1 and 3
		clear_seqs();
		seq_len = 10;
		full_seq[0] = 4'b0001;
		full_seq[6] = 4'b1010;
		full_seq[9] = 4'b0100;
		run_sequence(0, "separate OCT pulses");
	endtask

	task automatic compare_data_order();
		logic [AFI_DATA_WIDTH-1:0] word;
		logic [AFI_DATA_WIDTH-1:0] prev_word;
		prev_word = '0;
		for (int i = 0; i <= DATA_WORDS; i++)
		begin
			word = {$random(seed), $random(seed)};
			phy_dq_i = word;
			if (i > 0)
			begin
				check_value(afi_rdata_o, to_timeslot_major(prev_word),
					$sformatf("AFI data order, word %0d", i - 1));
				check_value(phy_mux_read_fifo_q_o, prev_word,
					$sformatf("sequencer data order, word %0d", i - 1));
			end
			prev_word = word;
			advance_cycle();
		end
	endtask

	// ********************
	// Main sequence
	// ********************

	initial
	begin
		seed = 32'hb35c;
		error_count = 0;
		check_count = 0;
		seq_len = 0;
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b1;
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
		seq_read_latency_counter_i = '0;
		phy_dq_i = '0;
		// A clean falling edge on reset before the first clock edge
		#1;
		reset_n_afi_clk = 1'b0;
		verify_reset_state();
		sweep_valid_latency();
		burst_reads();
		oct_window_reads();
		compare_data_order();
		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Stops a run that goes on past the longest expected test length
	initial
	begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("The run timed out after %0d clock cycles without finishing",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
rdp_width_pkg.sv
rdp_timing_pkg.sv
rdp_enable_align.sv
rdp_latency_shifter.sv
rdp_oct_window.sv
rdp_data_remap.sv
rdp_read_datapath.sv
rdp_read_datapath_asserts.sv
tb_rdp_read_datapath.sv
